//--- logic/sifhPkg.sv
package sifhPkg;

    localparam int tsWidth       = 12;  // TDC timestamp bits
    localparam int binWidth      = 6;   // histogram address bits
    localparam int binCount      = 64;
    localparam int countWidth    = 8;   // saturating bin counter
    localparam int eventsPerPass = 256;
    localparam int passCntWidth  = 9;   // must hold eventsPerPass

    typedef struct packed {
        logic               valid;
        logic [tsWidth-1:0] ts;
    } tdcEvent_t;

    typedef struct packed {
        logic                  en;
        logic [binWidth-1:0]   addr;
        logic [countWidth-1:0] data;
    } sramWr_t;

    typedef struct packed {
        logic                en;
        logic [binWidth-1:0] addr;
    } sramRd_t;

    typedef struct packed {
        logic [binWidth-1:0]   bin;
        logic [countWidth-1:0] count;
    } peakResult_t;

    typedef struct packed {
        logic [tsWidth-1:0]    ts;     // coarse bin in upper half, fine bin in lower half
        logic [countWidth-1:0] count;  // fine peak count
    } measResult_t;

    // measurement sequence, one entry per phase
    typedef enum logic [2:0] {
        CLEAR1,
        BUILD1,
        FIND1,
        FILTER,
        CLEAR2,
        BUILD2,
        FIND2,
        REPORT
    } sifhPhase_t;

endpackage

//--- logic/histSram.sv
`timescale 1ns/1ps

module histSram (
    input  logic                            clk,
    input  sifhPkg::sramWr_t                wr,
    input  sifhPkg::sramRd_t                rd,
    output logic [sifhPkg::countWidth-1:0]  rdData
);
    import sifhPkg::*;

    logic [countWidth-1:0] mem [binCount];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

//--- logic/histAccumulator.sv
`timescale 1ns/1ps

module histAccumulator (
    input  logic                            clk,
    input  logic                            res,
    input  sifhPkg::tdcEvent_t              binEvent,
    output sifhPkg::sramRd_t                rdReq,
    input  logic [sifhPkg::countWidth-1:0]  rdData,
    output sifhPkg::sramWr_t                wrReq
);
    import sifhPkg::*;

    logic [binWidth-1:0]   inAddr;

    logic                  s2Valid;
    logic                  s2Hit2;     // same bin as the event one ahead
    logic                  s2Hit3;     // same bin as the event two ahead
    logic [binWidth-1:0]   s2Addr;
    logic [countWidth-1:0] s2Fwd;

    logic                  s3Valid;
    logic [binWidth-1:0]   s3Addr;
    logic [countWidth-1:0] s3Data;

    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] nextCount;

    assign inAddr = binEvent.ts[binWidth-1:0];

    // stage 1 issues the read straight from the incoming event
    assign rdReq.en   = binEvent.valid;
    assign rdReq.addr = inAddr;

    // stage 3 is the write
    assign wrReq.en   = s3Valid;
    assign wrReq.addr = s3Addr;
    assign wrReq.data = s3Data;

    // The memory read misses both writes still pending at read time, so the
    // freshest value is taken from the pipeline instead. The event one ahead
    // is newest and wins over the one two ahead.
    always_comb begin
        if (s2Hit2) begin
            baseCount = s3Data;
        end else if (s2Hit3) begin
            baseCount = s2Fwd;
        end else begin
            baseCount = rdData;
        end
    end

    assign nextCount = (baseCount == {countWidth{1'b1}}) ? baseCount  // saturate
                                                          : baseCount + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
            s2Hit2  <= 1'b0;
            s2Hit3  <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s2Valid <= binEvent.valid;
            s2Hit2  <= binEvent.valid && s2Valid && (s2Addr == inAddr);
            s2Hit3  <= binEvent.valid && s3Valid && (s3Addr == inAddr);
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s2Addr <= inAddr;
        s2Fwd  <= s3Data;  // value being written now
        s3Addr <= s2Addr;
        s3Data <= nextCount;
    end

endmodule

//--- logic/peakSearch.sv
`timescale 1ns/1ps

module peakSearch (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            searchStart,
    output sifhPkg::sramRd_t                rdReq,
    input  logic [sifhPkg::countWidth-1:0]  rdData,
    output sifhPkg::peakResult_t            peak,
    output logic                            searchDone
);
    import sifhPkg::*;

    logic                  active;
    logic [binWidth-1:0]   addrCnt;
    logic                  lastAddr;
    logic                  cmpValid;   // rdData holds bin cmpBin
    logic                  cmpLast;
    logic [binWidth-1:0]   cmpBin;
    logic [binWidth-1:0]   bestBin;
    logic [countWidth-1:0] bestCount;

    assign lastAddr = (addrCnt == binWidth'(binCount - 1));

    assign rdReq.en   = active;
    assign rdReq.addr = addrCnt;

    assign peak.bin   = bestBin;
    assign peak.count = bestCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active     <= 1'b0;
            addrCnt    <= '0;
            cmpValid   <= 1'b0;
            cmpLast    <= 1'b0;
            searchDone <= 1'b0;
        end else begin
            cmpValid   <= active;
            cmpLast    <= active && lastAddr;
            searchDone <= cmpLast;  // best is final one cycle after last data
            if (searchStart) begin
                active  <= 1'b1;
                addrCnt <= '0;
            end else if (active) begin
                addrCnt <= addrCnt + 1'b1;
                if (lastAddr) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // strictly greater only, so a tie keeps the lower bin
    always_ff @(posedge clk) begin
        cmpBin <= addrCnt;
        if (searchStart) begin
            bestBin   <= '0;
            bestCount <= '0;
        end else if (cmpValid && (rdData > bestCount)) begin
            bestBin   <= cmpBin;
            bestCount <= rdData;
        end
    end

endmodule

//--- logic/sifhController.sv
`timescale 1ns/1ps

module sifhController (
    input  logic                  clk,
    input  logic                  res,
    input  sifhPkg::tdcEvent_t    tdcIn,
    output logic                  tdcEnable,
    output sifhPkg::tdcEvent_t    binEvent,
    output sifhPkg::sramWr_t      clearWr,
    output sifhPkg::sifhPhase_t   phase,
    output logic                  searchStart,
    input  sifhPkg::peakResult_t  peak,
    input  logic                  searchDone,
    output sifhPkg::measResult_t  result,
    output logic                  resultValid
);
    import sifhPkg::*;

    logic [binWidth-1:0]     clrAddr;
    logic [passCntWidth-1:0] evCnt;      // accepted events, binned or not
    logic [1:0]              drainCnt;
    logic [tsWidth-1:0]      thLow;      // TH-
    logic [tsWidth-1:0]      thHigh;     // TH+
    logic [tsWidth-1:0]      windowBase;

    logic clearing;
    logic building;
    logic passFull;
    logic accepted;
    logic inWindow;
    logic drainDone;

    assign clearing  = (phase == CLEAR1) || (phase == CLEAR2);
    assign building  = (phase == BUILD1) || (phase == BUILD2);
    assign passFull  = (evCnt == passCntWidth'(eventsPerPass));
    assign tdcEnable = building && !passFull;
    assign accepted  = tdcIn.valid && tdcEnable;
    assign inWindow  = (tdcIn.ts >= thLow) && (tdcIn.ts <= thHigh);
    assign drainDone = passFull && (drainCnt == 2'd2);  // third idle cycle

    // coarse pass bins on the upper bits, fine pass on the lower bits
    always_comb begin
        binEvent.valid = accepted && ((phase == BUILD1) || inWindow);
        binEvent.ts    = '0;
        if (phase == BUILD1) begin
            binEvent.ts[binWidth-1:0] = tdcIn.ts[tsWidth-1 -: binWidth];
        end else begin
            binEvent.ts[binWidth-1:0] = tdcIn.ts[binWidth-1:0];
        end
    end

    assign clearWr.en   = clearing && res;  // idle while reset is held
    assign clearWr.addr = clrAddr;
    assign clearWr.data = '0;

    assign resultValid  = (phase == REPORT);
    assign result.ts    = {thLow[tsWidth-1 -: binWidth], peak.bin};
    assign result.count = peak.count;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase       <= CLEAR1;
            clrAddr     <= '0;
            evCnt       <= '0;
            drainCnt    <= '0;
            searchStart <= 1'b0;
        end else begin
            searchStart <= 1'b0;
            case (phase)
                CLEAR1, CLEAR2: begin
                    clrAddr <= clrAddr + 1'b1;  // wraps back to zero
                    if (clrAddr == binWidth'(binCount - 1)) begin
                        phase <= (phase == CLEAR1) ? BUILD1 : BUILD2;
                    end
                end
                BUILD1, BUILD2: begin
                    if (accepted) begin
                        evCnt <= evCnt + 1'b1;
                    end
                    if (passFull) begin
                        drainCnt <= drainCnt + 1'b1;  // let the accumulator empty
                    end
                    if (drainDone) begin
                        evCnt       <= '0;
                        drainCnt    <= '0;
                        searchStart <= 1'b1;
                        phase       <= (phase == BUILD1) ? FIND1 : FIND2;
                    end
                end
                FIND1: begin
                    if (searchDone) begin
                        phase <= FILTER;
                    end
                end
                FILTER: begin
                    phase <= CLEAR2;
                end
                FIND2: begin
                    if (searchDone) begin
                        phase <= REPORT;
                    end
                end
                REPORT: begin
                    phase <= CLEAR1;  // next measurement
                end
                default: begin
                    phase <= CLEAR1;
                end
            endcase
        end
    end

    assign windowBase = {peak.bin, {binWidth{1'b0}}};

    // window from the coarse peak
    always_ff @(posedge clk) begin
        if (phase == FILTER) begin
            thLow  <= windowBase;
            thHigh <= windowBase + tsWidth'(binCount - 1);
        end
    end

endmodule

//--- logic/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                  clk,
    input  logic                  res,
    input  sifhPkg::tdcEvent_t    tdcIn,
    output logic                  tdcEnable,
    output sifhPkg::measResult_t  result,
    output logic                  resultValid
);
    import sifhPkg::*;

    tdcEvent_t             binEvent;
    sramWr_t               clearWr;
    sramWr_t               accWr;
    sramWr_t               memWr;
    sramRd_t               accRd;
    sramRd_t               searchRd;
    sramRd_t               memRd;
    sifhPhase_t            phase;
    logic                  searchStart;
    logic                  searchDone;
    peakResult_t           peak;
    logic [countWidth-1:0] rdData;

    // phases never overlap, so the phase alone picks the owner
    assign memWr = ((phase == CLEAR1) || (phase == CLEAR2)) ? clearWr : accWr;
    assign memRd = ((phase == FIND1) || (phase == FIND2)) ? searchRd : accRd;

    sifhController ctrl (
        .clk         (clk),
        .res         (res),
        .tdcIn       (tdcIn),
        .tdcEnable   (tdcEnable),
        .binEvent    (binEvent),
        .clearWr     (clearWr),
        .phase       (phase),
        .searchStart (searchStart),
        .peak        (peak),
        .searchDone  (searchDone),
        .result      (result),
        .resultValid (resultValid)
    );

    histAccumulator acc (
        .clk      (clk),
        .res      (res),
        .binEvent (binEvent),
        .rdReq    (accRd),
        .rdData   (rdData),
        .wrReq    (accWr)
    );

    peakSearch search (
        .clk         (clk),
        .res         (res),
        .searchStart (searchStart),
        .rdReq       (searchRd),
        .rdData      (rdData),
        .peak        (peak),
        .searchDone  (searchDone)
    );

    histSram sram (
        .clk    (clk),
        .wr     (memWr),
        .rd     (memRd),
        .rdData (rdData)
    );

endmodule

//--- bench/sifhTop_properties.sv
`timescale 1ns/1ps

module sifhTopProperties (
    input logic                 clk,
    input logic                 res,
    input logic                 tdcEnable,
    input logic                 resultValid,
    input logic                 searchDone,
    input sifhPkg::sifhPhase_t  phase,
    input sifhPkg::sramWr_t     clearWr,
    input sifhPkg::sramWr_t     accWr,
    input sifhPkg::sramRd_t     accRd,
    input sifhPkg::sramRd_t     searchRd
);
    import sifhPkg::*;

    enableInBuild: assert property (@(posedge clk) disable iff (!res)
        tdcEnable |-> (phase == BUILD1 || phase == BUILD2))
        else $error("tdcEnable high outside the build phases");

    resultPulse: assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid)
        else $error("resultValid longer than one cycle");

    singleWriter: assert property (@(posedge clk) disable iff (!res)
        !(clearWr.en && accWr.en))
        else $error("clear and accumulator write the memory together");

    singleReader: assert property (@(posedge clk) disable iff (!res)
        !(accRd.en && searchRd.en))
        else $error("accumulator and peak search read the memory together");

    quietInReset: assert property (@(posedge clk)
        !res |-> !tdcEnable && !resultValid && !clearWr.en && !accWr.en && !accRd.en
                 && !searchRd.en && !searchDone)
        else $error("enable high during reset");

endmodule

bind sifhTop sifhTopProperties props (
    .clk         (clk),
    .res         (res),
    .tdcEnable   (tdcEnable),
    .resultValid (resultValid),
    .searchDone  (searchDone),
    .phase       (phase),
    .clearWr     (clearWr),
    .accWr       (accWr),
    .accRd       (accRd),
    .searchRd    (searchRd)
);

//--- bench/sifhTb.sv
`timescale 1ns/1ps

module sifhTb;
    import sifhPkg::*;

    localparam int clkPeriod      = 4;
    localparam int resetCycles    = 5;
    localparam int measCount      = 6;
    localparam int maxGap         = 3;  // idle cycles after an event, irregular test
    localparam int maxCount       = (1 << countWidth) - 1;
    localparam int eventSlots     = measCount * 2 * eventsPerPass * (maxGap + 1);
    localparam int watchdogCycles = 2 * (eventSlots + 4 * binCount * measCount);

    logic        clk;
    logic        res;
    tdcEvent_t   tdcIn;
    logic        tdcEnable;
    measResult_t result;
    logic        resultValid;

    integer                seed = 32'hf9d5_7b0c;
    int                    errorCount;
    int                    checkCount;
    logic [tsWidth-1:0]    stim [2*eventsPerPass];  // pass one, then pass two
    logic [tsWidth-1:0]    lastTs;
    logic [countWidth-1:0] lastCount;

    sifhTop uut (
        .clk         (clk),
        .res         (res),
        .tdcIn       (tdcIn),
        .tdcEnable   (tdcEnable),
        .result      (result),
        .resultValid (resultValid)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // histogram of one pass, lowest bin wins a tie
    task automatic passPeak(input int first, input bit fine, input logic [binWidth-1:0] window,
                            output logic [binWidth-1:0] bin, output logic [countWidth-1:0] count);
        int                  hist [binCount] = '{default: 0};
        logic [binWidth-1:0] upper;
        logic [binWidth-1:0] slot;
        for (int i = first; i < first + eventsPerPass; i++) begin
            upper = stim[i][tsWidth-1 -: binWidth];
            slot  = fine ? stim[i][binWidth-1:0] : upper;
            if ((!fine || upper == window) && hist[slot] < maxCount) begin
                hist[slot]++;  // dropped events still use up a pass slot
            end
        end
        bin   = '0;
        count = '0;
        for (int b = 0; b < binCount; b++) begin
            if (hist[b] > int'(count)) begin
                bin   = binWidth'(b);
                count = countWidth'(hist[b]);
            end
        end
    endtask

    task automatic runMeasurement(input string testName, input bit gaps, input bit strays);
        int                    sent;
        int                    idle;
        logic [binWidth-1:0]   coarseBin;
        logic [binWidth-1:0]   fineBin;
        logic [countWidth-1:0] coarseCount;
        logic [countWidth-1:0] expCount;
        sent = 0;
        idle = 0;
        passPeak(0, 1'b0, '0, coarseBin, coarseCount);
        passPeak(eventsPerPass, 1'b1, coarseBin, fineBin, expCount);
        while (sent < 2 * eventsPerPass) begin
            nextCycle();
            tdcIn.valid = 1'b0;
            tdcIn.ts    = tsWidth'($random(seed));
            if (!tdcEnable) begin
                tdcIn.valid = strays;  // engine must ignore these
            end else if (idle > 0) begin
                idle--;
            end else begin
                tdcIn.valid = 1'b1;
                tdcIn.ts    = stim[sent];
                sent++;
                if (gaps) begin
                    idle = int'($unsigned($random(seed)) % (maxGap + 1));
                end
            end
        end
        nextCycle();
        tdcIn.valid = 1'b0;
        while (!resultValid) begin
            tdcIn.valid = strays;
            tdcIn.ts    = tsWidth'($random(seed));
            nextCycle();
        end
        checkValue({testName, " ts"}, 32'({coarseBin, fineBin}), 32'(result.ts));
        checkValue({testName, " count"}, 32'(expCount), 32'(result.count));
        lastTs    = result.ts;
        lastCount = result.count;
        tdcIn.valid = 1'b0;
        nextCycle();
        checkValue({testName, " pulse"}, 32'd0, 32'(resultValid));
    endtask

    task automatic testReset();
        repeat (resetCycles) begin
            nextCycle();
            checkValue("reset tdcEnable", 32'd0, 32'(tdcEnable));
            checkValue("reset resultValid", 32'd0, 32'(resultValid));
        end
        res = 1'b1;
        repeat (binCount) begin
            checkValue("clear tdcEnable", 32'd0, 32'(tdcEnable));
            checkValue("clear resultValid", 32'd0, 32'(resultValid));
            nextCycle();
        end
        checkValue("enable after clear", 32'd1, 32'(tdcEnable));
    endtask

    task automatic testSharpPeak();
        for (int i = 0; i < 2 * eventsPerPass; i++) begin
            stim[i] = 12'hABC;
        end
        runMeasurement("sharp peak", 1'b0, 1'b0);
        checkValue("sharp peak value", 32'h0000_0ABC, 32'(lastTs));
        checkValue("sharp peak saturation", 32'(maxCount), 32'(lastCount));
    endtask

    task automatic testWindow();
        logic [binWidth-1:0] lower;
        for (int i = 0; i < eventsPerPass; i++) begin
            lower   = binWidth'($random(seed));
            stim[i] = (i % 5 == 0) ? {binWidth'(i), lower} : {6'd42, lower};
        end
        for (int i = eventsPerPass; i < 2 * eventsPerPass; i++) begin
            lower = binWidth'($random(seed)) & 6'h0F;
            case (i % 6)
                0:       stim[i] = 12'hA7F;  // just below TH-
                3:       stim[i] = 12'hAC0;  // just above TH+
                default: stim[i] = {6'd42, lower + 6'd24};
            endcase
        end
        runMeasurement("window", 1'b0, 1'b0);
    endtask

    task automatic testTie();
        for (int i = 0; i < eventsPerPass; i++) begin
            stim[i] = {6'd5, binWidth'(i)};
        end
        for (int i = eventsPerPass; i < 2 * eventsPerPass; i++) begin
            stim[i] = {6'd5, (i % 2 == 0) ? 6'd40 : 6'd12};
        end
        runMeasurement("tie", 1'b0, 1'b0);
        checkValue("tie lower bin", 32'h0000_014C, 32'(lastTs));
        checkValue("tie count", 32'd128, 32'(lastCount));
    endtask

    task automatic testIrregular();
        logic [binWidth-1:0]   coarseBin;
        logic [countWidth-1:0] coarseCount;
        for (int i = 0; i < eventsPerPass; i++) begin
            stim[i] = tsWidth'($random(seed));
        end
        passPeak(0, 1'b0, '0, coarseBin, coarseCount);
        for (int i = eventsPerPass; i < 2 * eventsPerPass; i++) begin
            stim[i] = tsWidth'($random(seed));
            if ($random(seed) % 2 == 0) begin
                stim[i][tsWidth-1 -: binWidth] = coarseBin;  // about half in window
            end
        end
        runMeasurement("irregular", 1'b1, 1'b1);
    endtask

    // a stale first histogram would win both passes of the second run
    task automatic testContinuous();
        for (int i = 0; i < 2 * eventsPerPass; i++) begin
            stim[i] = 12'h100;
        end
        runMeasurement("continuous first", 1'b0, 1'b0);
        for (int i = 0; i < eventsPerPass; i++) begin
            stim[i] = {6'd9, binWidth'(i)};
        end
        for (int i = eventsPerPass; i < 2 * eventsPerPass; i++) begin
            stim[i] = {6'd9, binWidth'(i % 32 + 16)};
        end
        runMeasurement("continuous second", 1'b0, 1'b0);
        checkValue("continuous independent", 32'h0000_0250, 32'(lastTs));
        checkValue("continuous count", 32'd8, 32'(lastCount));
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        res        = 1'b0;
        tdcIn      = '0;
        testReset();
        testSharpPeak();
        testWindow();
        testTie();
        testIrregular();
        testContinuous();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog: tests did not finish within %0d cycles", watchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- sifhTop.f
logic/sifhPkg.sv
logic/histSram.sv
logic/histAccumulator.sv
logic/peakSearch.sv
logic/sifhController.sv
logic/sifhTop.sv
bench/sifhTop_properties.sv
bench/sifhTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= sifhTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
